// ==== files.f ====
+incdir+include
logic/fetch_pkg.sv
logic/rvc_pkg.sv
logic/fetch_if.sv
logic/axil_fetch_master.sv
logic/inst_aligner.sv
logic/rvc_expander.sv
logic/fetch_top.sv
tests/axil_mem_model.sv
tests/fetch_tb.sv

// ==== include/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// pc the core fetches from after reset
`define FETCH_RESET_PC 32'h0000_0200

// byte address width of the fetch port
`define FETCH_ADDR_W 32

// width of one instruction memory word
`define FETCH_WORD_W 32

// width of one instruction parcel
`define FETCH_PARCEL_W 16

`endif

// ==== logic/axil_fetch_master.sv ====
`default_nettype none

`include "fetch_config.svh"

module axil_fetch_master
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         n_rst,
    input  logic         redirect_valid,
    input  addr_t        redirect_pc,
    output addr_t        araddr,
    output logic [2:0]   arprot,
    output logic         arvalid,
    input  logic         arready,
    input  word_t        rdata,
    input  logic [1:0]   rresp, // error beats are taken as data
    input  logic         rvalid,
    output logic         rready,
    fetch_word_if.source word
);
    localparam addr_t reset_word = `FETCH_RESET_PC & ~addr_t'(3);

    fetch_state_e state;
    addr_t        fetch_addr;   // word being read or held
    addr_t        restart_addr; // target saved while a stale read drains
    word_t        rdata_q;
    logic         discard;
    logic         rd_busy;
    addr_t        target_word;

    assign target_word = {redirect_pc[`FETCH_ADDR_W-1:2], 2'b00};

    // AR pending, or AR accepted and R not yet seen
    assign rd_busy = (state == ADDR) || (state == DATA && !rvalid);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            fetch_addr <= reset_word;
            discard    <= 1'b0;
        end else if (redirect_valid) begin
            if (rd_busy) begin
                discard <= 1'b1; // let the old read finish first
                if (state == ADDR && arready) begin
                    state <= DATA;
                end
            end else begin
                fetch_addr <= target_word;
                discard    <= 1'b0;
                state      <= ADDR;
            end
        end else begin
            case (state)
                IDLE: state <= ADDR;
                ADDR: begin
                    if (arready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (rvalid && discard) begin
                        fetch_addr <= restart_addr;
                        discard    <= 1'b0;
                        state      <= ADDR;
                    end else if (rvalid) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (word.ready) begin
                        fetch_addr <= fetch_addr + addr_t'(4);
                        state      <= ADDR;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            restart_addr <= target_word;
        end
        if (state == DATA && rvalid) begin
            rdata_q <= rdata;
        end
    end

    assign arvalid = (state == ADDR);
    assign araddr  = fetch_addr;
    assign arprot  = 3'b100; // unprivileged, secure, instruction
    assign rready  = (state == DATA);

    assign word.valid = (state == HOLD);
    assign word.data  = rdata_q;
    assign word.addr  = fetch_addr;

endmodule

`default_nettype wire

// ==== logic/fetch_if.sv ====
`default_nettype none

// words from the read master to the aligner
interface fetch_word_if
    import fetch_pkg::*;
();
    logic  valid;
    logic  ready;
    word_t data;
    addr_t addr; // word address of data

    modport source (output valid, data, addr, input ready);
    modport sink (input valid, data, addr, output ready);
endinterface

// whole raw instructions from the aligner to the expander
interface fetch_inst_if
    import fetch_pkg::*;
();
    logic  valid;
    logic  ready;
    word_t inst;       // parcel in the low half when compressed
    addr_t pc;
    logic  compressed;

    modport source (output valid, inst, pc, compressed, input ready);
    modport sink (input valid, inst, pc, compressed, output ready);
endinterface

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] addr_t;     // byte address
    typedef logic [`FETCH_WORD_W-1:0] word_t;     // memory word or full instruction
    typedef logic [`FETCH_PARCEL_W-1:0] parcel_t; // one half-word parcel

    // read master
    typedef enum logic [1:0] {
        IDLE = 2'b00, // out of reset
        ADDR = 2'b01, // AR presented
        DATA = 2'b10, // waiting on R
        HOLD = 2'b11  // word held for the aligner
    } fetch_state_e;

    // parcel aligner
    typedef enum logic [1:0] {
        EMPTY = 2'b00, // nothing pending, next word starts an instruction
        UPPER = 2'b01, // upper half of the current word still to use
        SPLIT = 2'b10  // low half of a 32-bit instruction buffered
    } align_state_e;

endpackage

`default_nettype wire

// ==== logic/fetch_top.sv ====
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       redirect_valid,
    input  addr_t      redirect_pc,
    output addr_t      araddr,
    output logic [2:0] arprot,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic [1:0] rresp,
    input  logic       rvalid,
    output logic       rready,
    output logic       out_valid,
    input  logic       out_ready,
    output word_t      out_inst,
    output addr_t      out_pc,
    output logic       out_compressed,
    output logic       out_illegal
);
    fetch_word_if u_word_if ();
    fetch_inst_if u_inst_if ();

    axil_fetch_master u_master (
        .clk            (clk),
        .n_rst          (n_rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .araddr         (araddr),
        .arprot         (arprot),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .word           (u_word_if.source)
    );

    inst_aligner u_aligner (
        .clk            (clk),
        .n_rst          (n_rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .word           (u_word_if.sink),
        .inst           (u_inst_if.source)
    );

    rvc_expander u_expander (
        .clk            (clk),
        .n_rst          (n_rst),
        .redirect_valid (redirect_valid),
        .inst           (u_inst_if.sink),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_inst       (out_inst),
        .out_pc         (out_pc),
        .out_compressed (out_compressed),
        .out_illegal    (out_illegal)
    );

endmodule

`default_nettype wire

// ==== logic/inst_aligner.sv ====
`default_nettype none

`include "fetch_config.svh"

module inst_aligner
    import fetch_pkg::*;
    import rvc_pkg::*;
(
    input  logic         clk,
    input  logic         n_rst,
    input  logic         redirect_valid,
    input  addr_t        redirect_pc,
    fetch_word_if.sink   word,
    fetch_inst_if.source inst
);
    localparam addr_t reset_pc = `FETCH_RESET_PC;

    align_state_e state, next_state;
    addr_t        pc;        // pc of the next instruction to emit
    parcel_t      cur_hi;    // upper half of the current word
    logic         cur_valid; // cur_hi loaded, cleared after a misaligned redirect
    parcel_t      pending;   // low half of a split instruction
    parcel_t      upper;
    addr_t        base_pc;

    logic  o_valid;
    word_t o_inst;
    addr_t o_pc;
    logic  o_comp;

    logic  out_free, advance, fresh;
    logic  take, emit, emit_comp, step4, load_cur, load_pend;
    word_t emit_inst;

    assign out_free = !o_valid || inst.ready;
    assign advance  = out_free && !redirect_valid;
    assign upper    = cur_valid ? cur_hi : word.data[31:16];

    // on a fresh word the upper pc bits come from its address
    assign base_pc = fresh ? {word.addr[`FETCH_ADDR_W-1:2], pc[1:0]} : pc;

    always_comb begin
        next_state = state;
        fresh      = 1'b0;
        take       = 1'b0;
        emit       = 1'b0;
        emit_inst  = word.data;
        emit_comp  = 1'b0;
        step4      = 1'b0;
        load_cur   = 1'b0;
        load_pend  = 1'b0;
        case (state)
            EMPTY: begin
                fresh = 1'b1;
                if (advance && word.valid) begin
                    take = 1'b1;
                    emit = 1'b1;
                    if (word.data[1:0] == FULL) begin
                        step4 = 1'b1; // aligned 32-bit word passes whole
                    end else begin
                        emit_inst  = {16'h0000, word.data[15:0]};
                        emit_comp  = 1'b1;
                        load_cur   = 1'b1;
                        next_state = UPPER;
                    end
                end
            end
            UPPER: begin
                fresh = !cur_valid;
                if (advance && (cur_valid || word.valid)) begin
                    take = !cur_valid;
                    if (upper[1:0] == FULL) begin
                        load_pend  = 1'b1; // wait for the next word
                        next_state = SPLIT;
                    end else begin
                        emit       = 1'b1;
                        emit_inst  = {16'h0000, upper};
                        emit_comp  = 1'b1;
                        next_state = EMPTY;
                    end
                end
            end
            SPLIT: begin
                if (advance && word.valid) begin
                    take       = 1'b1;
                    emit       = 1'b1;
                    step4      = 1'b1;
                    emit_inst  = {word.data[15:0], pending};
                    load_cur   = 1'b1;
                    next_state = UPPER;
                end
            end
            default: next_state = EMPTY;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= reset_pc[1] ? UPPER : EMPTY;
            pc        <= reset_pc;
            cur_valid <= 1'b0;
            o_valid   <= 1'b0;
        end else if (redirect_valid) begin
            state     <= redirect_pc[1] ? UPPER : EMPTY; // odd half-word skips the low parcel
            pc        <= redirect_pc;
            cur_valid <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            state <= next_state;
            if (emit) begin
                pc <= base_pc + (step4 ? addr_t'(4) : addr_t'(2));
            end
            if (load_cur) begin
                cur_valid <= 1'b1;
            end else if (next_state != UPPER) begin
                cur_valid <= 1'b0;
            end
            if (emit) begin
                o_valid <= 1'b1;
            end else if (inst.ready) begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_cur) begin
            cur_hi <= word.data[31:16];
        end
        if (load_pend) begin
            pending <= upper;
        end
        if (emit) begin
            o_inst <= emit_inst;
            o_pc   <= base_pc;
            o_comp <= emit_comp;
        end
    end

    assign word.ready      = take;
    assign inst.valid      = o_valid;
    assign inst.inst       = o_inst;
    assign inst.pc         = o_pc;
    assign inst.compressed = o_comp;

endmodule

`default_nettype wire

// ==== logic/rvc_expander.sv ====
`default_nettype none

module rvc_expander
    import fetch_pkg::*;
    import rvc_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       redirect_valid,
    fetch_inst_if.sink inst,
    output logic       out_valid,
    input  logic       out_ready,
    output word_t      out_inst,
    output addr_t      out_pc,
    output logic       out_compressed,
    output logic       out_illegal
);
    parcel_t       p;
    rvc_quadrant_e quad;
    rvc_op_e       op;
    logic [4:0]    rd, rs2, rdp, rs1p;
    logic [11:0]   i_imm, ls_imm;
    logic [12:0]   b_imm;
    logic [20:0]   j_imm;
    word_t         exp_inst;
    logic          exp_illegal;

    assign p    = inst.inst[15:0];
    assign quad = rvc_quadrant_e'(p[1:0]);
    assign op   = rvc_op_e'(p[15:13]);
    assign rd   = p[11:7];
    assign rs2  = p[6:2];
    assign rdp  = {2'b01, p[4:2]}; // x8..x15
    assign rs1p = {2'b01, p[9:7]};

    assign i_imm  = {{6{p[12]}}, p[12], p[6:2]};
    assign ls_imm = {5'b0, p[5], p[12:10], p[6], 2'b00}; // word offset, zero extended
    assign b_imm  = {{4{p[12]}}, p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0};
    assign j_imm  = {{9{p[12]}}, p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};

    always_comb begin
        exp_inst    = '0;
        exp_illegal = 1'b0;
        if (!inst.compressed) begin
            exp_inst = inst.inst;
        end else begin
            exp_illegal = 1'b1; // cleared by each supported form
            case (quad)
                Q0: begin
                    if (op == C_LW_LI) begin
                        exp_inst    = {ls_imm, rs1p, 3'b010, rdp, LOAD};
                        exp_illegal = 1'b0;
                    end else if (op == C_SW_BEQZ) begin
                        exp_inst    = {ls_imm[11:5], rdp, rs1p, 3'b010, ls_imm[4:0], STORE};
                        exp_illegal = 1'b0;
                    end
                end
                Q1: begin
                    exp_illegal = 1'b0;
                    case (op)
                        C_ADDI:    exp_inst = {i_imm, rd, 3'b000, rd, OP_IMM}; // c.nop too
                        C_LW_LI:   exp_inst = {i_imm, 5'd0, 3'b000, rd, OP_IMM};
                        C_LUI: begin
                            exp_inst    = {{14{p[12]}}, p[12], p[6:2], rd, LUI};
                            exp_illegal = (rd == 5'd2); // c.addi16sp
                        end
                        C_J: begin
                            exp_inst = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                                        5'd0, JAL};
                        end
                        C_SW_BEQZ, C_BNEZ: begin
                            exp_inst = {b_imm[12], b_imm[10:5], 5'd0, rs1p, 2'b00, p[13],
                                        b_imm[4:1], b_imm[11], BRANCH};
                        end
                        default:   exp_illegal = 1'b1;
                    endcase
                    if (exp_illegal) begin
                        exp_inst = '0;
                    end
                end
                Q2: begin
                    // rs2 of zero is c.jr / c.jalr / c.ebreak
                    if (op == C_MV_ADD && rs2 != 5'd0) begin
                        exp_inst    = {7'b0, rs2, p[12] ? rd : 5'd0, 3'b000, rd, OP};
                        exp_illegal = 1'b0;
                    end
                end
                default: exp_illegal = 1'b1;
            endcase
        end
    end

    assign inst.ready = !out_valid || out_ready;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            out_valid <= 1'b0;
        end else if (redirect_valid) begin
            out_valid <= 1'b0;
        end else if (inst.ready) begin
            out_valid <= inst.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst.valid && inst.ready) begin
            out_inst       <= exp_inst;
            out_pc         <= inst.pc;
            out_compressed <= inst.compressed;
            out_illegal    <= exp_illegal;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rvc_pkg.sv ====
`default_nettype none

package rvc_pkg;

    // low two bits of a parcel
    typedef enum logic [1:0] {
        Q0   = 2'b00,
        Q1   = 2'b01,
        Q2   = 2'b10,
        FULL = 2'b11 // not compressed
    } rvc_quadrant_e;

    // funct3 of the supported compressed forms, meaning depends on the quadrant
    typedef enum logic [2:0] {
        C_ADDI    = 3'b000, // q1, also c.nop
        C_LW_LI   = 3'b010, // q0 c.lw, q1 c.li
        C_LUI     = 3'b011, // q1
        C_MV_ADD  = 3'b100, // q2, split on bit 12
        C_J       = 3'b101, // q1
        C_SW_BEQZ = 3'b110, // q0 c.sw, q1 c.beqz
        C_BNEZ    = 3'b111  // q1
    } rvc_op_e;

    // RV32 major opcodes the expansions land on
    typedef enum logic [6:0] {
        LOAD   = 7'b000_0011,
        OP_IMM = 7'b001_0011,
        STORE  = 7'b010_0011,
        OP     = 7'b011_0011,
        LUI    = 7'b011_0111,
        BRANCH = 7'b110_0011,
        JAL    = 7'b110_1111
    } rv_opcode_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the fetch front end with Verilator and run the testbench.
set -u

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE="${BUILD_DIR}/sim.log"

mkdir -p "${BUILD_DIR}"
if [ $? -ne 0 ]; then
    echo "could not create ${BUILD_DIR}"
    exit 1
fi

verilator --binary --timing -f files.f --top-module fetch_tb \
    -Mdir "${BUILD_DIR}/obj" -o fetch_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"${BUILD_DIR}/obj/fetch_sim" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"

if grep -q "TEST RESULT: FAIL" "${LOG_FILE}"; then
    exit 1
fi
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi
exit 0

// ==== tests/axil_mem_model.sv ====
`default_nettype none

module axil_mem_model
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic [1:0] resp_delay, // cycles from AR to R
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);
    localparam int DEPTH = 256; // words, covers 0x000..0x3ff

    word_t      mem [0:DEPTH-1];
    logic       busy;
    logic [1:0] count;
    addr_t      addr_q;

    // every word gets its own byte address as a marker
    task automatic fill_pattern();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'h0bad_0000 | word_t'(i << 2);
        end
    endtask

    task automatic load_word(input addr_t addr, input word_t data);
        mem[addr[9:2]] = data;
    endtask

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
            count  <= 2'd0;
            addr_q <= '0;
            rdata  <= '0;
        end else if (!busy) begin
            if (arvalid) begin
                busy   <= 1'b1;
                addr_q <= araddr;
                count  <= resp_delay;
            end
        end else if (!rvalid) begin
            if (count == 2'd0) begin
                rvalid <= 1'b1;
                rdata  <= mem[addr_q[9:2]];
            end else begin
                count <= count - 2'd1;
            end
        end else if (rready) begin
            rvalid <= 1'b0; // one read at a time
            busy   <= 1'b0;
        end
    end

    assign arready = !busy;
    assign rresp   = 2'b00; // OKAY

endmodule

`default_nettype wire

// ==== tests/fetch_tb.sv ====
`default_nettype none

`include "fetch_config.svh"

module fetch_tb
    import fetch_pkg::*;
    import rvc_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 4000;
    localparam addr_t START_PC    = `FETCH_RESET_PC;

    logic       clk;
    logic       n_rst;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       out_ready = 1'b1;
    logic [1:0] mem_delay = 2'd0;
    addr_t      araddr;
    logic [2:0] arprot;
    logic       arvalid, arready, rvalid, rready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       out_valid, out_compressed, out_illegal;
    word_t      out_inst;
    addr_t      out_pc;

    logic [31:0] lcg_state = 32'd44;
    int          cycle_count = 0;
    logic        random_ready;
    logic        hold_check;
    logic        stalled;
    word_t       held_inst;
    addr_t       held_pc;

    word_t image[$];
    word_t exp_inst[$];
    addr_t exp_pc[$];
    logic  exp_comp[$];
    logic  exp_ill[$];
    word_t got_inst[$];
    addr_t got_pc[$];
    logic  got_comp[$];
    logic  got_ill[$];

    fetch_top u_dut (
        .clk            (clk),
        .n_rst          (n_rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .araddr         (araddr),
        .arprot         (arprot),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_inst       (out_inst),
        .out_pc         (out_pc),
        .out_compressed (out_compressed),
        .out_illegal    (out_illegal)
    );

    axil_mem_model u_mem (
        .clk        (clk),
        .n_rst      (n_rst),
        .resp_delay (mem_delay),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // memory delay every cycle, out_ready only when back-pressure is on
    always @(posedge clk) begin : lcg_drive
        logic [31:0] r;
        r = lcg_next();
        mem_delay <= r[17:16];
        if (random_ready) begin
            out_ready <= (r[25:24] != 2'b00);
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic compare_inst(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %08h expected %08h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic compare_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got pc %08h expected %08h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %b expected %b", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic compare_prot(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %03b expected %03b", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "arprot mismatch");
        end
    endtask

    // every read address goes out as an instruction access
    always @(posedge clk) begin
        if (n_rst && arvalid) begin
            compare_prot(arprot, 3'b100, "arprot");
        end
    end

    // collects every accepted output, a redirect or reset drops what came before
    always @(posedge clk) begin
        if (!n_rst || redirect_valid) begin
            got_inst.delete();
            got_pc.delete();
            got_comp.delete();
            got_ill.delete();
            stalled = 1'b0;
        end else begin
            if (hold_check && stalled) begin
                compare_flag(out_valid, 1'b1, "out_valid under stall");
                compare_inst(out_inst, held_inst, "out_inst under stall");
                compare_pc(out_pc, held_pc, "out_pc under stall");
            end
            if (out_valid && out_ready) begin
                got_inst.push_back(out_inst);
                got_pc.push_back(out_pc);
                got_comp.push_back(out_compressed);
                got_ill.push_back(out_illegal);
            end
            stalled   = out_valid && !out_ready;
            held_inst = out_inst;
            held_pc   = out_pc;
        end
    end

    task automatic clear_test();
        image.delete();
        exp_inst.delete();
        exp_pc.delete();
        exp_comp.delete();
        exp_ill.delete();
    endtask

    task automatic expect_item(input word_t inst, input addr_t pc, input logic comp,
                               input logic ill);
        exp_inst.push_back(inst);
        exp_pc.push_back(pc);
        exp_comp.push_back(comp);
        exp_ill.push_back(ill);
    endtask

    task automatic load_program(input addr_t base);
        for (int i = 0; i < image.size(); i++) begin
            u_mem.load_word(base + addr_t'(4 * i), image[i]);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        n_rst <= 1'b0;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
    endtask

    task automatic check_outputs(input string name);
        while (got_inst.size() < exp_inst.size()) begin
            @(posedge clk);
        end
        for (int i = 0; i < exp_inst.size(); i++) begin
            compare_pc(got_pc[i], exp_pc[i], $sformatf("%s item %0d pc", name, i));
            compare_inst(got_inst[i], exp_inst[i], $sformatf("%s item %0d inst", name, i));
            compare_flag(got_comp[i], exp_comp[i], $sformatf("%s item %0d compressed", name, i));
            compare_flag(got_ill[i], exp_ill[i], $sformatf("%s item %0d illegal", name, i));
        end
        $display("%s: %0d instructions checked", name, exp_inst.size());
    endtask

    task automatic aligned_stream_test();
        clear_test();
        for (int i = 0; i < 5; i++) begin
            image.push_back(32'h0000_0093 | word_t'((i + 1) << 20)); // addi x1, x0, i+1
            expect_item(image[i], START_PC + addr_t'(4 * i), 1'b0, 1'b0);
        end
        load_program(START_PC);
        apply_reset();
        check_outputs("aligned stream");
    endtask

    // c.addi x10,-3 | add x10,x11,x12 straddling | c.li x5,7 | c.mv x11,x12 | c.lui x6,1
    task automatic mixed_image();
        clear_test();
        image.push_back(32'h8533_1575);
        image.push_back(32'h429d_00c5);
        image.push_back(32'h6305_85b2);
        image.push_back(32'h0040_0093);
        expect_item(32'hffd5_0513, START_PC, 1'b1, 1'b0);
        expect_item(32'h00c5_8533, START_PC + 32'h2, 1'b0, 1'b0);
        expect_item(32'h0070_0293, START_PC + 32'h6, 1'b1, 1'b0);
        expect_item(32'h00c0_05b3, START_PC + 32'h8, 1'b1, 1'b0);
        expect_item(32'h0000_1337, START_PC + 32'ha, 1'b1, 1'b0);
        expect_item(32'h0040_0093, START_PC + 32'hc, 1'b0, 1'b0);
    endtask

    task automatic mixed_stream_test();
        mixed_image();
        load_program(START_PC);
        apply_reset();
        check_outputs("mixed stream");
    endtask

    task automatic rvc_expansion_test();
        word_t expansions[12];
        parcel_t parcels[12];
        clear_test();
        parcels = '{16'h1575, 16'h0001, 16'h429d, 16'h6305, 16'h85b2, 16'h95b2,
                    16'ha021, 16'hc011, 16'hfcf5, 16'h4144, 16'hc504, 16'h8082};
        expansions = '{32'hffd5_0513, // addi x10, x10, -3
                       32'h0000_0013, // nop
                       32'h0070_0293, // addi x5, x0, 7
                       32'h0000_1337, // lui x6, 1
                       32'h00c0_05b3, // add x11, x0, x12
                       32'h00c5_85b3, // add x11, x11, x12
                       32'h0080_006f, // jal x0, 8
                       32'h0004_0263, // beq x8, x0, 4
                       32'hfe04_9ee3, // bne x9, x0, -4
                       32'h0045_2483, // lw x9, 4(x10)
                       32'h0095_2423, // sw x9, 8(x10)
                       32'h0000_0000};// c.jr is outside the subset
        for (int i = 0; i < 12; i += 2) begin
            image.push_back({parcels[i + 1], parcels[i]});
        end
        for (int i = 0; i < 12; i++) begin
            expect_item(expansions[i], START_PC + addr_t'(2 * i), 1'b1, i == 11);
        end
        load_program(START_PC);
        apply_reset();
        check_outputs("rvc expansion");
    endtask

    task automatic redirect_test();
        addr_t target;
        target = 32'h0000_0302;
        clear_test();
        for (int i = 0; i < 8; i++) begin
            image.push_back(32'h0000_0113 | word_t'((i + 1) << 20)); // old stream
        end
        load_program(START_PC);
        image.delete();
        image.push_back(32'h8533_0001); // low parcel must be skipped
        image.push_back(32'h429d_00c5);
        image.push_back(32'h0040_0093);
        load_program({target[31:2], 2'b00});
        expect_item(32'h00c5_8533, target, 1'b0, 1'b0);
        expect_item(32'h0070_0293, target + 32'h4, 1'b1, 1'b0);
        expect_item(32'h0040_0093, target + 32'h6, 1'b0, 1'b0);
        apply_reset();
        while (got_inst.size() < 1) begin
            @(posedge clk);
        end
        @(posedge clk);
        while (!(rready && !rvalid)) begin
            @(posedge clk); // read in flight
        end
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        @(posedge clk);
        redirect_valid <= 1'b0;
        @(posedge clk);
        check_outputs("redirect");
    endtask

    task automatic back_pressure_test();
        mixed_image();
        load_program(START_PC);
        random_ready <= 1'b1;
        hold_check   <= 1'b1;
        apply_reset();
        check_outputs("back pressure");
        random_ready <= 1'b0;
        hold_check   <= 1'b0;
    endtask

    initial begin
        n_rst          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        random_ready   = 1'b0;
        hold_check     = 1'b0;
        stalled        = 1'b0;
        u_mem.fill_pattern();
        aligned_stream_test();
        mixed_stream_test();
        rvc_expansion_test();
        redirect_test();
        back_pressure_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
